// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTBENCH FAILED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/axi_master_ctrl.sv
`timescale 1ns/1ps

module axi_master_ctrl (
  input  logic clk,
  input  logic rstn,
  input  logic req,
  input  logic write,
  output logic ack,
  output logic capture,
  output logic rsp_load,
  output logic awvalid,
  input  logic awready,
  output logic wvalid,
  input  logic wready,
  input  logic bvalid,
  output logic bready,
  output logic arvalid,
  input  logic arready,
  input  logic rvalid,
  output logic rready
);

  cpu_bus_pkg::bridge_state_t state;
  cpu_bus_pkg::bridge_state_t state_nxt;
  logic w_done;
  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic ar_fire;
  logic r_fire;

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;
  assign b_fire  = bvalid && bready;
  assign ar_fire = arvalid && arready;
  assign r_fire  = rvalid && rready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= cpu_bus_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      cpu_bus_pkg::IDLE: begin
        if (req) begin
          state_nxt = write ? cpu_bus_pkg::AW : cpu_bus_pkg::AR;
        end
      end
      cpu_bus_pkg::AR: if (ar_fire) state_nxt = cpu_bus_pkg::R;
      cpu_bus_pkg::R:  if (r_fire) state_nxt = cpu_bus_pkg::DONE;
      cpu_bus_pkg::AW: begin
        // W may have gone through before or together with AW
        if (aw_fire) begin
          state_nxt = (w_done || w_fire) ? cpu_bus_pkg::B : cpu_bus_pkg::W;
        end
      end
      cpu_bus_pkg::W: if (w_fire) state_nxt = cpu_bus_pkg::B;
      cpu_bus_pkg::B: if (b_fire) state_nxt = cpu_bus_pkg::DONE;
      // Hold the reply until the CPU lets go of req
      cpu_bus_pkg::DONE: if (!req) state_nxt = cpu_bus_pkg::IDLE;
      default: state_nxt = cpu_bus_pkg::IDLE;
    endcase
  end

  // Data beat accepted while still waiting on AW
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      w_done <= 1'b0;
    end else if (capture) begin
      w_done <= 1'b0;
    end else if (state == cpu_bus_pkg::AW && w_fire) begin
      w_done <= 1'b1;
    end
  end

  assign capture  = (state == cpu_bus_pkg::IDLE) && req;
  assign rsp_load = b_fire || r_fire;
  assign ack      = (state == cpu_bus_pkg::DONE);

  assign awvalid = (state == cpu_bus_pkg::AW);
  assign wvalid  = ((state == cpu_bus_pkg::AW) && !w_done) || (state == cpu_bus_pkg::W);
  assign bready  = (state == cpu_bus_pkg::B);
  assign arvalid = (state == cpu_bus_pkg::AR);
  assign rready  = (state == cpu_bus_pkg::R);

  a_aw_hold: assert property (@(posedge clk) disable iff (!rstn)
    awvalid && !awready |=> awvalid);

  a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
    arvalid && !arready |=> arvalid);

  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rstn)
    $rose(ack) |-> $past(req));

endmodule

// File: hw/axi_master_regs.sv
`timescale 1ns/1ps

module axi_master_regs (
  input  logic                  clk,
  input  logic                  rstn,
  input  cpu_bus_pkg::cpu_cmd_t cmd,
  input  logic                  capture,
  input  logic                  rsp_load,
  input  axi_pkg::axi_b_t       b,
  input  axi_pkg::axi_r_t       r,
  output axi_pkg::axi_aw_t      aw,
  output axi_pkg::axi_w_t       w,
  output axi_pkg::axi_ar_t      ar,
  output cpu_bus_pkg::cpu_rsp_t rsp
);

  // Full word per beat
  localparam logic [2:0] FULL_SIZE = 3'($clog2(axi_pkg::AXI_STRB_BITS));

  cpu_bus_pkg::cpu_cmd_t cmd_q;

  always_ff @(posedge clk) begin
    if (capture) begin
      cmd_q <= cmd;
    end
  end

  always_comb begin
    aw.id    = '0;
    aw.addr  = cmd_q.addr;
    aw.len   = '0;
    aw.size  = FULL_SIZE;
    aw.burst = axi_pkg::BURST_INCR;

    ar.id    = '0;
    ar.addr  = cmd_q.addr;
    ar.len   = '0;
    ar.size  = FULL_SIZE;
    ar.burst = axi_pkg::BURST_INCR;

    w.data = cmd_q.wdata;
    w.strb = cmd_q.strb;
    w.last = 1'b1;
  end

  // Writes return zero data, only the response code matters
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rsp <= '0;
    end else if (rsp_load) begin
      if (cmd_q.write) begin
        rsp.rdata <= '0;
        rsp.err   <= (b.resp != axi_pkg::RESP_OKAY);
      end else begin
        rsp.rdata <= r.data;
        rsp.err   <= (r.resp != axi_pkg::RESP_OKAY);
      end
    end
  end

  a_no_overlap: assert property (@(posedge clk) disable iff (!rstn)
    !(capture && rsp_load));

endmodule

// File: hw/axi_pkg.sv
package axi_pkg;

  localparam int AXI_ADDR_BITS = 32;
  localparam int AXI_DATA_BITS = 32;
  localparam int AXI_STRB_BITS = AXI_DATA_BITS / 8;
  localparam int AXI_ID_BITS   = 4;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  localparam logic [1:0] BURST_INCR = 2'b01;

  // Write address channel
  typedef struct packed {
    logic [AXI_ID_BITS-1:0]   id;
    logic [AXI_ADDR_BITS-1:0] addr;
    logic [7:0]               len;
    logic [2:0]               size;
    logic [1:0]               burst;
  } axi_aw_t;

  typedef struct packed {
    logic [AXI_DATA_BITS-1:0] data;
    logic [AXI_STRB_BITS-1:0] strb;
    logic                     last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_ID_BITS-1:0] id;
    logic [1:0]             resp;
  } axi_b_t;

  // Read address channel, same layout as AW
  typedef struct packed {
    logic [AXI_ID_BITS-1:0]   id;
    logic [AXI_ADDR_BITS-1:0] addr;
    logic [7:0]               len;
    logic [2:0]               size;
    logic [1:0]               burst;
  } axi_ar_t;

  typedef struct packed {
    logic [AXI_ID_BITS-1:0]   id;
    logic [AXI_DATA_BITS-1:0] data;
    logic [1:0]               resp;
    logic                     last;
  } axi_r_t;

endpackage

// File: hw/axi_sram_slave.sv
`timescale 1ns/1ps

module axi_sram_slave #(
  parameter int MEM_WORDS = 256
) (
  input  logic             clk,
  input  logic             rstn,
  input  axi_pkg::axi_aw_t aw,
  input  logic             awvalid,
  output logic             awready,
  input  axi_pkg::axi_w_t  w,
  input  logic             wvalid,
  output logic             wready,
  output axi_pkg::axi_b_t  b,
  output logic             bvalid,
  input  logic             bready,
  input  axi_pkg::axi_ar_t ar,
  input  logic             arvalid,
  output logic             arready,
  output axi_pkg::axi_r_t  r,
  output logic             rvalid,
  input  logic             rready
);

  localparam int IDX_BITS = $clog2(MEM_WORDS);

  logic [axi_pkg::AXI_DATA_BITS-1:0] mem [MEM_WORDS] = '{default: '0};

  logic                wr_fire;
  logic                rd_fire;
  logic                wr_hit;
  logic                rd_hit;
  logic [IDX_BITS-1:0] wr_idx;
  logic [IDX_BITS-1:0] rd_idx;

  assign wr_fire = awvalid && awready && wvalid && wready;
  assign rd_fire = arvalid && arready;

  // Byte offset bits are dropped, anything above the index must be zero
  assign wr_idx = aw.addr[IDX_BITS+1:2];
  assign rd_idx = ar.addr[IDX_BITS+1:2];
  assign wr_hit = (aw.addr[axi_pkg::AXI_ADDR_BITS-1:IDX_BITS+2] == '0);
  assign rd_hit = (ar.addr[axi_pkg::AXI_ADDR_BITS-1:IDX_BITS+2] == '0);

  // Write side
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      // One cycle ready pulse once both AW and W are waiting
      awready <= awvalid && wvalid && !bvalid && !awready;
      wready  <= awvalid && wvalid && !bvalid && !wready;
      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      b.id   <= aw.id;
      b.resp <= wr_hit ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire && wr_hit) begin
      for (int i = 0; i < axi_pkg::AXI_STRB_BITS; i++) begin
        if (w.strb[i]) begin
          mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
        end
      end
    end
  end

  // Read side
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= arvalid && !rvalid && !arready;
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      r.id   <= ar.id;
      r.data <= rd_hit ? mem[rd_idx] : '0;
      r.resp <= rd_hit ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
      r.last <= 1'b1;
    end
  end

  a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
    bvalid && !bready |=> bvalid);

  a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
    rvalid && !rready |=> rvalid);

endmodule

// File: hw/axi_sys_top.sv
`timescale 1ns/1ps

module axi_sys_top #(
  parameter int MEM_WORDS = 256
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  req,
  input  cpu_bus_pkg::cpu_cmd_t cmd,
  output logic                  ack,
  output cpu_bus_pkg::cpu_rsp_t rsp
);

  logic capture;
  logic rsp_load;

  axi_pkg::axi_aw_t aw;
  axi_pkg::axi_w_t  w;
  axi_pkg::axi_b_t  b;
  axi_pkg::axi_ar_t ar;
  axi_pkg::axi_r_t  r;

  logic awvalid;
  logic awready;
  logic wvalid;
  logic wready;
  logic bvalid;
  logic bready;
  logic arvalid;
  logic arready;
  logic rvalid;
  logic rready;

  axi_master_ctrl i_ctrl (
    .clk     (clk),
    .rstn    (rstn),
    .req     (req),
    .write   (cmd.write),
    .ack     (ack),
    .capture (capture),
    .rsp_load(rsp_load),
    .awvalid (awvalid),
    .awready (awready),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready),
    .arvalid (arvalid),
    .arready (arready),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  axi_master_regs i_regs (
    .clk     (clk),
    .rstn    (rstn),
    .cmd     (cmd),
    .capture (capture),
    .rsp_load(rsp_load),
    .b       (b),
    .r       (r),
    .aw      (aw),
    .w       (w),
    .ar      (ar),
    .rsp     (rsp)
  );

  // Bus target beside the bridge
  axi_sram_slave #(
    .MEM_WORDS(MEM_WORDS)
  ) i_sram (
    .clk    (clk),
    .rstn   (rstn),
    .aw     (aw),
    .awvalid(awvalid),
    .awready(awready),
    .w      (w),
    .wvalid (wvalid),
    .wready (wready),
    .b      (b),
    .bvalid (bvalid),
    .bready (bready),
    .ar     (ar),
    .arvalid(arvalid),
    .arready(arready),
    .r      (r),
    .rvalid (rvalid),
    .rready (rready)
  );

endmodule

// File: hw/cpu_bus_pkg.sv
package cpu_bus_pkg;

  // Held stable by the CPU while req is high
  typedef struct packed {
    logic                             write;
    logic [axi_pkg::AXI_ADDR_BITS-1:0] addr;
    logic [axi_pkg::AXI_DATA_BITS-1:0] wdata;
    logic [axi_pkg::AXI_STRB_BITS-1:0] strb;
  } cpu_cmd_t;

  // Valid while ack is high
  typedef struct packed {
    logic [axi_pkg::AXI_DATA_BITS-1:0] rdata;
    logic                             err;
  } cpu_rsp_t;

  typedef enum logic [2:0] {
    IDLE,
    AR,
    R,
    AW,
    W,
    B,
    DONE
  } bridge_state_t;

endpackage

// File: sim/tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
  parameter int MEM_WORDS = 256
) (
  input logic                  clk,
  input logic                  rstn,
  input logic                  req,
  input cpu_bus_pkg::cpu_cmd_t cmd,
  input logic                  ack,
  input cpu_bus_pkg::cpu_rsp_t rsp
);

  logic [31:0] model [MEM_WORDS];

  int errors = 0;
  int checks = 0;
  int tests = 0;
  int test_checks = 0;
  int test_errors = 0;

  // Values seen at the previous rising edge
  logic                  rstn_q = 1'b1;
  logic                  req_q = 1'b0;
  logic                  ack_q = 1'b0;
  cpu_bus_pkg::cpu_rsp_t rsp_q = '0;

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      model[i] = '0;
    end
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    test_checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("ERR %0t ns %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // Expected reply from the command that is still held on the CPU side
  task automatic check_reply();
    int          idx;
    logic        in_range;
    logic [31:0] exp_data;
    idx = int'(cmd.addr[31:2]);
    in_range = (idx < MEM_WORDS);
    exp_data = '0;
    if (in_range && cmd.write) begin
      for (int i = 0; i < 4; i++) begin
        if (cmd.strb[i]) begin
          model[idx][8*i +: 8] = cmd.wdata[8*i +: 8];
        end
      end
    end else if (in_range) begin
      exp_data = model[idx];
    end
    compare("rsp.rdata", exp_data, rsp.rdata);
    compare("rsp.err", 32'(!in_range), 32'(rsp.err));
  endtask

  always @(posedge clk) begin
    if (!rstn_q) begin
      compare("ack", 32'd0, 32'(ack));
      compare("rsp.rdata", 32'd0, rsp.rdata);
      compare("rsp.err", 32'd0, 32'(rsp.err));
    end else if (ack && !ack_q) begin
      check_reply();
    end else if (ack_q && req_q) begin
      // CPU still holding req, reply must not move
      compare("ack", 32'd1, 32'(ack));
      compare("rsp.rdata", rsp_q.rdata, rsp.rdata);
      compare("rsp.err", 32'(rsp_q.err), 32'(rsp.err));
    end else if (ack_q && !req_q) begin
      compare("ack", 32'd0, 32'(ack));
    end
    rstn_q = rstn;
    req_q  = req;
    ack_q  = ack;
    rsp_q  = rsp;
  end

  task automatic end_test(input string name);
    tests++;
    $display("test %-16s %s  checks %0d errors %0d", name,
             (test_errors == 0) ? "ok" : "bad", test_checks, test_errors);
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic report_counts();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
  endtask

endmodule

// File: sim/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  localparam int MEM_WORDS = 256;
  localparam int WAIT_LIMIT = 50;

  logic                  clk = 1'b0;
  logic                  rstn;
  logic                  req;
  cpu_bus_pkg::cpu_cmd_t cmd;
  logic                  ack;
  cpu_bus_pkg::cpu_rsp_t rsp;

  logic [31:0] rng = 32'h558aacac;
  logic        timed_out = 1'b0;

  always #50 clk = ~clk;

  axi_sys_top #(
    .MEM_WORDS(MEM_WORDS)
  ) i_dut (
    .clk (clk),
    .rstn(rstn),
    .req (req),
    .cmd (cmd),
    .ack (ack),
    .rsp (rsp)
  );

  tb_checker #(
    .MEM_WORDS(MEM_WORDS)
  ) i_chk (
    .clk (clk),
    .rstn(rstn),
    .req (req),
    .cmd (cmd),
    .ack (ack),
    .rsp (rsp)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Polls 1 ns after each rising edge
  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    if (timed_out) return;
    while (ack !== level && n < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (ack !== level) begin
      $display("Timeout at %0t ns: ack did not go to %0d within %0d cycles",
               $time, level, WAIT_LIMIT);
      timed_out = 1'b1;
    end
  endtask

  // One four-phase transfer with req held hold extra cycles after ack
  task automatic do_op(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                       input logic [3:0] strb, input int hold);
    if (timed_out) return;
    cmd.write = wr;
    cmd.addr  = addr;
    cmd.wdata = data;
    cmd.strb  = strb;
    req       = 1'b1;
    wait_ack(1'b1);
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    req = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic random_op(input int max_hold);
    logic        wr;
    logic [3:0]  strb;
    logic [31:0] data;
    logic [31:0] addr;
    int          hold;
    rng = xorshift(rng);
    wr = rng[0];
    strb = rng[7:4];
    hold = int'(rng[15:8]) % (max_hold + 1);
    rng = xorshift(rng);
    data = rng;
    rng = xorshift(rng);
    // Roughly one in eight beyond the memory
    if (rng[2:0] == 3'd0) begin
      addr = 32'h400 + {16'b0, rng[31:16]};
    end else begin
      addr = {22'b0, rng[31:22]};
    end
    do_op(wr, addr, data, strb, hold);
  endtask

  initial begin
    rstn = 1'b0;
    req  = 1'b0;
    cmd  = '0;
    repeat (3) @(posedge clk);
    #1;
    rstn = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    i_chk.end_test("reset");

    do_op(1'b1, 32'h0000_0040, 32'hdead_beef, 4'hf, 0);
    do_op(1'b0, 32'h0000_0040, 32'h0, 4'h0, 0);
    i_chk.end_test("write_read");

    do_op(1'b1, 32'h0000_0040, 32'h1122_3344, 4'b0101, 0);
    do_op(1'b0, 32'h0000_0042, 32'h0, 4'h0, 0);
    do_op(1'b1, 32'h0000_0080, 32'ha5a5_a5a5, 4'b1000, 0);
    do_op(1'b0, 32'h0000_0080, 32'h0, 4'h0, 0);
    i_chk.end_test("byte_strobes");

    // Word 0 must stay clear if the address wrapped
    do_op(1'b1, 32'h0000_0400, 32'hffff_ffff, 4'hf, 0);
    do_op(1'b0, 32'h0000_0400, 32'h0, 4'h0, 0);
    do_op(1'b0, 32'h0000_0000, 32'h0, 4'h0, 0);
    do_op(1'b0, 32'hffff_fffc, 32'h0, 4'h0, 0);
    i_chk.end_test("out_of_range");

    for (int i = 0; i < 300; i++) begin
      random_op(0);
    end
    i_chk.end_test("random_mix");

    for (int i = 0; i < 40; i++) begin
      random_op(10);
    end
    i_chk.end_test("four_phase_hold");

    i_chk.report_counts();
    if (timed_out || i_chk.errors != 0) begin
      $display("TESTBENCH FAILED");
    end else begin
      $display("TESTBENCH PASSED");
    end
    $finish;
  end

endmodule

// File: src.f
hw/axi_pkg.sv
hw/cpu_bus_pkg.sv
hw/axi_master_ctrl.sv
hw/axi_master_regs.sv
hw/axi_sram_slave.sv
hw/axi_sys_top.sv
sim/tb_checker.sv
sim/tb_top.sv
